/* Makefile */
SIM   = verilator
FLAGS = --binary --timing --assert
TOP   = tb_synth_boot
FLIST = all.f
BUILD = obj_dir
BIN   = $(BUILD)/V$(TOP)
LOG   = sim.log
SRCS  = $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* all.f */
common/boot_pkg.sv
common/patch_pkg.sv
power_sequencer/power_sequencer.sv
verilog/preset_regs.sv
verilog/dac_volume_ramp.sv
verilog/synth_boot_top.sv
verification/synth_boot_assert.sv
verification/tb_synth_boot.sv

/* common/boot_pkg.sv */
// boot sequencer definitions
// state encoding and cycle count type shared by the sequencer and the top level

package boot_pkg;

	// cycle counter for state timing, boot age and the timing parameters
	typedef logic [15:0] boot_count_t;

	// power-up order of the board
	// each state names what the board is doing while it sits there
	typedef enum logic [2:0] {
		IDLE_WAIT,   // rails settling after rst release, counting to the PLL pulse
		PLL_RESET,   // pll_areset held high
		WAIT_LOCK,   // pulse done, waiting for pll_locked
		SYS_RESET,   // synth system reset asserted for the hold time
		PRESET_LOAD, // single cycle, default patch loaded, ready raised
		RUN_MUTED,   // running, DAC held at zero volume
		RUN          // running and unmuted
	} boot_state_t;

	// states from here on watch for loss of PLL lock
	// WAIT_LOCK itself just keeps waiting

endpackage

/* common/patch_pkg.sv */
// patch definitions
// field widths, the patch register layout, pot selector codes and the power-up patch

package patch_pkg;

	typedef logic [6:0] volume_t;    // DAC volume code, 0 is silent
	typedef logic [7:0] pot_value_t; // raw reading from one front panel pot

	// which patch field a pot write lands in
	typedef enum logic [3:0] {
		POT_ATTACK,
		POT_DECAY,
		POT_SUSTAIN,
		POT_RELEASE,
		POT_CUTOFF,
		POT_OSC,
		POT_TEMPO,
		POT_EFFECT,
		POT_VOLUME
	} pot_sel_t;

	// full voice setup, 8 pot fields plus the master volume
	typedef struct packed {
		pot_value_t attack;       // envelope
		pot_value_t decay;
		pot_value_t sustain;
		pot_value_t release_time;
		pot_value_t cutoff;       // filter
		pot_value_t osc_shape;    // oscillator waveform
		pot_value_t tempo;        // step sequencer rate
		pot_value_t effect_mix;   // dry/wet
		volume_t    master_volume; // ramp target for the DAC
	} patch_t;

	// power-up patch, a soft pad at a moderate tempo
	localparam patch_t PATCH_DEFAULT = '{
		attack:        8'h10,
		decay:         8'h40,
		sustain:       8'hc0,
		release_time:  8'h60,
		cutoff:        8'h80,
		osc_shape:     8'h00, // saw
		tempo:         8'h78, // 120 bpm
		effect_mix:    8'h20,
		master_volume: 7'h30  // quietest audible level
	};

endpackage

/* power_sequencer/power_sequencer.sv */
// power sequencer for the synth board
// pulses the PLL reset, waits for lock, holds the system reset, loads the default
// patch, flags ready and unmutes the DAC once the board is old enough

`timescale 1ns/1ps

module power_sequencer import boot_pkg::*; #(
	parameter boot_count_t AREST_START = 10,  // cycle of the first PLL reset pulse
	parameter boot_count_t AREST_LEN   = 2,   // PLL reset pulse width
	parameter boot_count_t RESET_HOLD  = 8,   // system reset width after lock
	parameter boot_count_t UNMUTE_MIN  = 100  // earliest unmute, counted from rst release
) (
	input  logic clk,
	input  logic rst,
	input  logic pll_locked,
	input  logic dac_ready,
	output logic pll_areset,
	output logic sys_rst,
	output logic sys_rst_n,
	output logic ready,       // to the microcontroller
	output logic preset_load, // one-cycle strobe to the patch registers
	output logic unmute       // to the volume ramp
);

	boot_state_t state;
	boot_count_t cnt;     // cycles spent in the current state
	boot_count_t age_cnt; // cycles since rst release, saturates
	logic        age_done;
	logic        lock_lost;

	assign age_done  = (age_cnt >= UNMUTE_MIN);
	assign lock_lost = !pll_locked && (state inside {SYS_RESET, PRESET_LOAD, RUN_MUTED, RUN});

	// boot age keeps running through a lock-loss restart
	always_ff @(posedge clk) begin
		if (rst) begin
			age_cnt <= '0;
		end else if (!age_done) begin
			age_cnt <= age_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= IDLE_WAIT;
			cnt         <= '0;
			pll_areset  <= 1'b0;
			sys_rst     <= 1'b0;
			sys_rst_n   <= 1'b1;
			ready       <= 1'b0;
			preset_load <= 1'b0;
			unmute      <= 1'b0;
		end else begin
			preset_load <= 1'b0; // strobe, only set on the way out of SYS_RESET
			cnt         <= cnt + 1'b1;
			if (lock_lost) begin
				// drop everything and go straight back to the PLL pulse
				state      <= PLL_RESET;
				cnt        <= '0;
				pll_areset <= 1'b1;
				sys_rst    <= 1'b0;
				sys_rst_n  <= 1'b1;
				ready      <= 1'b0;
				unmute     <= 1'b0;
			end else begin
				case (state)
					IDLE_WAIT: if (cnt == AREST_START - 1'b1) begin
						state      <= PLL_RESET;
						cnt        <= '0;
						pll_areset <= 1'b1; // high from cycle AREST_START
					end
					PLL_RESET: if (cnt == AREST_LEN - 1'b1) begin
						state      <= WAIT_LOCK;
						cnt        <= '0;
						pll_areset <= 1'b0;
					end
					WAIT_LOCK: begin
						cnt <= '0; // lock time is unbounded, no timing here
						if (pll_locked) begin
							state     <= SYS_RESET;
							sys_rst   <= 1'b1;
							sys_rst_n <= 1'b0;
						end
					end
					SYS_RESET: if (cnt == RESET_HOLD - 1'b1) begin
						state       <= PRESET_LOAD;
						sys_rst     <= 1'b0;
						sys_rst_n   <= 1'b1;
						preset_load <= 1'b1;
						ready       <= 1'b1; // patch registers open for pots from here
					end
					PRESET_LOAD: state <= RUN_MUTED;
					RUN_MUTED: if (age_done && dac_ready) begin
						state  <= RUN;
						unmute <= 1'b1;
					end
					RUN: if (!dac_ready) begin
						state  <= RUN_MUTED; // wait for the DAC to come back
						unmute <= 1'b0;
					end
					default: begin
						state <= IDLE_WAIT;
						cnt   <= '0;
					end
				endcase
			end
		end
	end

endmodule

/* verification/synth_boot_assert.sv */
// sequencer output checks
// bound into power_sequencer, watches the reset pair, load strobe and unmute

`timescale 1ns/1ps

module synth_boot_assert (
	input logic clk,
	input logic rst,
	input logic pll_areset,
	input logic sys_rst,
	input logic sys_rst_n,
	input logic ready,
	input logic preset_load,
	input logic unmute
);

	// the two reset polarities move together
	rst_pair: assert property (@(posedge clk) disable iff (rst) sys_rst_n == !sys_rst)
		else $error("sys_rst_n is not the complement of sys_rst");

	load_pulse: assert property (@(posedge clk) disable iff (rst) preset_load |=> !preset_load)
		else $error("preset_load held longer than one cycle");

	unmute_ready: assert property (@(posedge clk) disable iff (rst) unmute |-> ready)
		else $error("unmute high while ready is low");

	// PLL pulse and system reset never at once
	no_overlap: assert property (@(posedge clk) disable iff (rst) !(pll_areset && sys_rst))
		else $error("pll_areset and sys_rst high together");

endmodule

bind power_sequencer synth_boot_assert i_synth_boot_assert (
	.clk        (clk),
	.rst        (rst),
	.pll_areset (pll_areset),
	.sys_rst    (sys_rst),
	.sys_rst_n  (sys_rst_n),
	.ready      (ready),
	.preset_load(preset_load),
	.unmute     (unmute)
);

/* verification/tb_synth_boot.sv */
// testbench for the synth board bring-up
// PLL and DAC models, directed tests of boot order, patch writes and volume ramp

`timescale 1ns/1ps

module tb_synth_boot import patch_pkg::*; ();

	localparam int AREST_START = 10;
	localparam int AREST_LEN   = 2;
	localparam int RESET_HOLD  = 8;
	localparam int UNMUTE_MIN  = 100;
	localparam int RAMP_DIV    = 4;
	localparam int MAX_CYCLES  = 3000; // tests take about 1200 cycles with the longest lock delays

	logic       clk;
	logic       rst;
	logic       pll_locked;
	logic       dac_ready;
	logic       pot_wr;
	pot_sel_t   pot_sel;
	pot_value_t pot_value;
	logic       pll_areset;
	logic       sys_rst;
	logic       sys_rst_n;
	logic       ready;
	patch_t     patch;
	volume_t    volume;

	integer seed = 32'h142e;
	int     cyc;        // sample index counted from the first cycle with rst low
	int     lock_delay;
	int     cycle_cnt;

	synth_boot_top i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// PLL model raises lock 3 to 18 cycles after the reset pulse ends
	initial begin
		forever begin
			@(negedge pll_areset);
			if (!rst) begin // ignore the X to 0 settle at power-up
				lock_delay = 3 + int'($unsigned($random(seed)) % 16);
				repeat (lock_delay) @(posedge clk);
				pll_locked <= 1'b1;
			end
		end
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < MAX_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		abort_run("timeout, the tests did not finish within the cycle limit");
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic value_error(input string msg);
		abort_run($sformatf("[ERROR] %0t: %s", $time, msg));
	endtask

	task automatic next_sample();
		@(negedge clk); // mid cycle where outputs are settled
		cyc++;
	endtask

	// one-cycle pot strobe that returns on the cycle the write should be visible
	task automatic drive_pot(input pot_sel_t sel, input pot_value_t val);
		@(posedge clk);
		pot_wr    <= 1'b1;
		pot_sel   <= sel;
		pot_value <= val;
		next_sample();
		@(posedge clk);
		pot_wr <= 1'b0;
		next_sample();
	endtask

	task automatic compare_patch(input patch_t exp);
		assert (patch == exp) else value_error($sformatf("patch %h, expected %h", patch, exp));
	endtask

	task automatic verify_idle();
		assert (!pll_areset && !sys_rst && sys_rst_n && !ready)
			else value_error($sformatf("controls not idle, areset %0b sys_rst %0b n %0b ready %0b",
				pll_areset, sys_rst, sys_rst_n, ready));
		assert (volume == '0) else value_error($sformatf("volume %0h while idle", volume));
		compare_patch(PATCH_DEFAULT);
	endtask

	task automatic measure_areset(output int start);
		int len;
		len = 0;
		while (!pll_areset) begin
			assert (!sys_rst) else value_error("sys_rst high before the PLL reset pulse");
			next_sample();
		end
		start = cyc;
		while (pll_areset) begin
			len++;
			next_sample();
		end
		assert (len == AREST_LEN)
			else value_error($sformatf("pll_areset high %0d cycles, expected %0d", len, AREST_LEN));
	endtask

	// lock, reset hold, ready and preset load
	task automatic watch_reset_hold();
		logic locked_prev;
		int   len;
		locked_prev = 1'b0;
		len = 0;
		while (!sys_rst) begin
			assert (!locked_prev) else value_error("sys_rst low the cycle after lock");
			locked_prev = pll_locked;
			next_sample();
		end
		assert (locked_prev) else value_error("sys_rst high before pll_locked");
		while (sys_rst) begin
			assert (!sys_rst_n && !ready) else value_error("sys_rst_n or ready high in reset hold");
			len++;
			next_sample();
		end
		assert (len == RESET_HOLD)
			else value_error($sformatf("sys_rst high %0d cycles, expected %0d", len, RESET_HOLD));
		assert (ready && sys_rst_n) else value_error("ready low when the reset hold ended");
		next_sample(); // preset load lands here
		compare_patch(PATCH_DEFAULT);
	endtask

	// first step within first_max cycles and then one code every RAMP_DIV
	task automatic follow_ramp(input volume_t target, input int first_max);
		volume_t prev;
		volume_t step;
		int      gap;
		int      steps;
		prev = volume;
		gap = 0;
		steps = 0;
		while (volume != target) begin
			next_sample();
			gap++;
			if (volume != prev) begin
				step = (target > prev) ? prev + 7'd1 : prev - 7'd1;
				assert (volume == step)
					else value_error($sformatf("volume %0h after %0h, expected %0h", volume, prev, step));
				if (steps == 0) begin
					assert (gap <= first_max) else value_error($sformatf("first step after %0d", gap));
				end else begin
					assert (gap == RAMP_DIV) else value_error($sformatf("step spacing %0d", gap));
				end
				prev = volume;
				gap = 0;
				steps++;
			end else begin
				assert (gap < first_max + RAMP_DIV) else abort_run("volume stopped short of target");
			end
		end
	endtask

	task automatic reset_release();
		repeat (3) @(posedge clk);
		@(negedge clk);
		verify_idle();
		@(posedge clk);
		rst       <= 1'b0;
		dac_ready <= 1'b1; // DAC up early so boot age alone gates unmute
		@(negedge clk);
		cyc = 0;
		verify_idle();
	endtask

	task automatic first_pll_pulse();
		int start;
		measure_areset(start);
		assert (start == AREST_START)
			else value_error($sformatf("pll_areset rose at %0d, expected %0d", start, AREST_START));
	endtask

	task automatic lock_and_reset_hold();
		drive_pot(POT_CUTOFF, 8'hff); // ignored before ready
		compare_patch(PATCH_DEFAULT);
		watch_reset_hold();
	endtask

	task automatic unmute_and_ramp();
		while (volume == '0) begin
			assert (cyc <= UNMUTE_MIN + RAMP_DIV + 2) else abort_run("volume never left zero");
			next_sample();
		end
		assert (cyc > UNMUTE_MIN && volume == 7'd1)
			else value_error($sformatf("volume %0h at cycle %0d", volume, cyc));
		follow_ramp(7'h30, RAMP_DIV);
		@(posedge clk);
		dac_ready <= 1'b0;
		next_sample();
		next_sample();
		assert (volume == '0) else value_error($sformatf("volume %0h with DAC down", volume));
		@(posedge clk);
		dac_ready <= 1'b1;
		next_sample();
		follow_ramp(7'h30, RAMP_DIV + 3); // unmute and divider restart first
	endtask

	task automatic pot_writes();
		logic [70:0] exp_bits;
		pot_value_t  val;
		exp_bits = PATCH_DEFAULT;
		for (int i = 0; i < 8; i++) begin
			val = pot_value_t'($random(seed));
			drive_pot(pot_sel_t'(i), val);
			exp_bits[70 - 8 * i -: 8] = val; // attack sits at the top of patch_t
			compare_patch(patch_t'(exp_bits));
		end
		drive_pot(POT_VOLUME, 8'h20);
		assert (patch.master_volume == 7'h10) else value_error("volume write 8'h20 not 7'h10");
		follow_ramp(7'h10, RAMP_DIV + 1);
		drive_pot(POT_VOLUME, 8'h71);
		assert (patch.master_volume == 7'h38) else value_error("volume write 8'h71 not 7'h38");
		follow_ramp(7'h38, RAMP_DIV + 1);
	endtask

	task automatic lock_loss_restart();
		int start;
		@(posedge clk);
		pll_locked <= 1'b0;
		next_sample();
		next_sample();
		assert (pll_areset && !ready) else value_error("lock loss gave no PLL reset or kept ready");
		measure_areset(start);
		assert (volume == '0) else value_error($sformatf("volume %0h after lock loss", volume));
		watch_reset_hold();
		follow_ramp(7'h30, RAMP_DIV + 3); // back to the default level
	endtask

	initial begin
		rst        = 1'b1;
		pll_locked = 1'b0;
		dac_ready  = 1'b0;
		pot_wr     = 1'b0;
		pot_sel    = POT_ATTACK;
		pot_value  = '0;
		cyc        = 0;
		reset_release();
		first_pll_pulse();
		lock_and_reset_hold();
		unmute_and_ramp();
		pot_writes();
		lock_loss_restart();
		$display("Verification passed");
		$finish;
	end

endmodule

/* verilog/dac_volume_ramp.sv */
// DAC volume ramp
// steps the volume one code at a time toward the target so level changes do not click,
// mute drops straight to zero

`timescale 1ns/1ps

module dac_volume_ramp import patch_pkg::*; #(
	parameter int unsigned RAMP_DIV = 4 // cycles per volume step
) (
	input  logic    clk,
	input  logic    rst,
	input  logic    unmute,
	input  logic    dac_ready,
	input  volume_t target,
	output volume_t volume
);

	localparam int unsigned DIV_W = (RAMP_DIV > 1) ? $clog2(RAMP_DIV) : 1;
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(RAMP_DIV - 1);

	logic [DIV_W-1:0] div_cnt;
	logic             run;  // DAC allowed to play
	logic             tick; // one step due

	assign run  = unmute && dac_ready;
	assign tick = (div_cnt == DIV_LAST);

	// divider only runs while playing so each unmute starts a full step period
	always_ff @(posedge clk) begin
		if (rst || !run) begin
			div_cnt <= '0;
		end else if (tick) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || !run) begin
			volume <= '0; // mute bypasses the ramp
		end else if (tick) begin
			if (volume < target) begin
				volume <= volume + 1'b1;
			end else if (volume > target) begin
				volume <= volume - 1'b1;
			end
		end
	end

endmodule

/* verilog/preset_regs.sv */
// patch register block
// holds the voice setup, restored to the defaults on a preset load
// and updated field by field from pot writes once the board is ready

`timescale 1ns/1ps

module preset_regs import patch_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       preset_load, // from the sequencer
	input  logic       ready,       // pots ignored until boot completes
	input  logic       pot_wr,
	input  pot_sel_t   pot_sel,
	input  pot_value_t pot_value,
	output patch_t     patch
);

	logic wr_en;

	assign wr_en = pot_wr && ready;

	always_ff @(posedge clk) begin
		if (rst || preset_load) begin
			patch <= PATCH_DEFAULT;
		end else if (wr_en) begin
			case (pot_sel)
				POT_ATTACK:  patch.attack       <= pot_value;
				POT_DECAY:   patch.decay        <= pot_value;
				POT_SUSTAIN: patch.sustain      <= pot_value;
				POT_RELEASE: patch.release_time <= pot_value;
				POT_CUTOFF:  patch.cutoff       <= pot_value;
				POT_OSC:     patch.osc_shape    <= pot_value;
				POT_TEMPO:   patch.tempo        <= pot_value;
				POT_EFFECT:  patch.effect_mix   <= pot_value;
				// volume is 7 bits, drop the pot lsb
				POT_VOLUME:  patch.master_volume <= pot_value[7:1];
				default: ; // unused selector codes leave the patch alone
			endcase
		end
	end

endmodule

/* verilog/synth_boot_top.sv */
// synth board bring-up top
// power sequencer, patch registers and DAC volume ramp

`timescale 1ns/1ps

module synth_boot_top import boot_pkg::*, patch_pkg::*; #(
	parameter boot_count_t AREST_START = 10,
	parameter boot_count_t AREST_LEN   = 2,
	parameter boot_count_t RESET_HOLD  = 8,
	parameter boot_count_t UNMUTE_MIN  = 100,
	parameter int unsigned RAMP_DIV    = 4
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       pll_locked,
	input  logic       dac_ready,
	input  logic       pot_wr,
	input  pot_sel_t   pot_sel,
	input  pot_value_t pot_value,
	output logic       pll_areset,
	output logic       sys_rst,
	output logic       sys_rst_n,
	output logic       ready,
	output patch_t     patch,
	output volume_t    volume
);

	logic preset_load; // sequencer to registers
	logic unmute;      // sequencer to ramp

	power_sequencer #(
		.AREST_START(AREST_START),
		.AREST_LEN  (AREST_LEN),
		.RESET_HOLD (RESET_HOLD),
		.UNMUTE_MIN (UNMUTE_MIN)
	) i_power_sequencer (
		.clk        (clk),
		.rst        (rst),
		.pll_locked (pll_locked),
		.dac_ready  (dac_ready),
		.pll_areset (pll_areset),
		.sys_rst    (sys_rst),
		.sys_rst_n  (sys_rst_n),
		.ready      (ready),
		.preset_load(preset_load),
		.unmute     (unmute)
	);

	preset_regs i_preset_regs (
		.clk        (clk),
		.rst        (rst),
		.preset_load(preset_load),
		.ready      (ready),
		.pot_wr     (pot_wr),
		.pot_sel    (pot_sel),
		.pot_value  (pot_value),
		.patch      (patch)
	);

	// master volume from the patch is the ramp target
	dac_volume_ramp #(
		.RAMP_DIV(RAMP_DIV)
	) i_dac_volume_ramp (
		.clk      (clk),
		.rst      (rst),
		.unmute   (unmute),
		.dac_ready(dac_ready),
		.target   (patch.master_volume),
		.volume   (volume)
	);

endmodule
